//--- flist.f
+incdir+.
wm_pkg.sv
phase_timer.sv
pause_keeper.sv
cycle_fsm.sv
washer_top.sv
washer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module washer_tb \
    -f flist.f -o washer_sim \
    && ./obj_dir/washer_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
[ -s sim.log ] || exit 1
grep -q "sim failed" sim.log && exit 1 || exit 0

//--- washer_tb_checks.svh
int errors       = 0;
int errors_start = 0;  // Error count when the current test began
int tests_run    = 0;
int tests_failed = 0;

task automatic check_state(input string name, input wm_state_t got, input wm_state_t exp);
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_fault(input string name, input fault_t got, input fault_t exp);
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_count(input string name, input drain_count_t got, input drain_count_t exp);
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

// Phase lengths measured in cycles
task automatic check_time(input string name, input timer_count_t got, input timer_count_t exp);
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
endtask

task automatic begin_test();
    errors_start = errors;
endtask

task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_start) begin
        $display("test %0d %s: ok", tests_run, name);
    end else begin
        tests_failed++;
        $display("test %0d %s: FAILED, %0d errors", tests_run, name, errors - errors_start);
    end
endtask

//--- washer_tb.sv
`timescale 1ns/100ps

module washer_tb
    import wm_pkg::*;
();

    localparam int FILL_T     = 5;
    localparam int RS_T       = 5;
    localparam int MAX_CYCLES = 4000;  // Well above six tests of at most ~300 cycles

    typedef struct packed {
        wm_state_t    st;
        logic         lock;
        drain_count_t cnt;
        logic         entry;  // Phase entry pulse
        timer_count_t tcnt;
        fault_t       fault;
        wm_state_t    saved;
    } model_t;

    logic         clk = 1'b0;
    logic         rst;
    logic         pwr_btn;
    logic         start;
    logic         stop;
    logic         pause;
    logic         door_closed;
    logic         water_full;
    logic         load_present;
    wash_mode_t   mode;
    wm_state_t    state;
    logic         door_locked;
    drain_count_t drain_count;
    logic         timer_done;
    fault_t       fault_code;
    model_t       model;
    int           cycles = 0;

    `include "washer_tb_checks.svh"

    washer_top #(.FILL_TIME(FILL_T), .RINSE_SPIN_TIME(RS_T)) dut_i (.*);

    always #10 clk = ~clk;

    // Codes 6 and 7 run as normal
    function automatic timer_count_t exp_wash_time(input wash_mode_t md);
        timer_count_t cycles_by_mode [8];
        cycles_by_mode = '{8'd20, 8'd30, 8'd15, 8'd10, 8'd5, 8'd25, 8'd15, 8'd15};
        return cycles_by_mode[md];
    endfunction

    function automatic logic is_timed(input wm_state_t s);
        return s == FILL || s == WASH || s == RINSE || s == SPIN;
    endfunction

    function automatic timer_count_t phase_len(input wm_state_t s);
        case (s)
            FILL:        return timer_count_t'(FILL_T);
            WASH:        return exp_wash_time(mode);
            RINSE, SPIN: return timer_count_t'(RS_T);
            default:     return '0;
        endcase
    endfunction

    function automatic logic model_done(input model_t m);
        return is_timed(m.st) && m.tcnt == '0 && !m.entry;
    endfunction

    // Each fault waits for its sensor, a user pause for start
    function automatic logic model_resume(input model_t m);
        if (m.st != PAUSED) begin
            return 1'b0;
        end
        case (m.fault)
            FAULT_DOOR:  return door_closed;
            FAULT_WATER: return water_full;
            FAULT_LOAD:  return load_present;
            default:     return start;
        endcase
    endfunction

    // Expected machine one clock edge later
    function automatic model_t model_step(input model_t m);
        model_t n;
        fault_t why;
        n   = m;
        why = FAULT_NONE;
        if (m.st == OFF) begin
            n.lock = 1'b0;
            n.cnt  = '0;
        end
        if (!pwr_btn) begin
            n.st = OFF;
        end else begin
            case (m.st)
                OFF:  n.st = INIT;
                INIT: n.st = IDLE;
                IDLE: begin
                    if (start) n.st = FILL;
                end
                FILL: begin
                    if (stop) begin
                        n.st = DRAIN;
                    end else if (!door_closed || !load_present) begin
                        n.st = PAUSED;
                        why  = door_closed ? FAULT_LOAD : FAULT_DOOR;  // Door checked first
                    end else if (water_full) begin
                        n.st   = WASH;
                        n.lock = 1'b1;
                    end else if (model_done(m)) begin
                        n.st = PAUSED;
                        why  = FAULT_WATER;
                    end
                end
                WASH: begin
                    if (model_done(m)) n.st = DRAIN;
                    else if (pause) n.st = PAUSED;
                    else if (stop) n.st = DRAIN;
                end
                RINSE, SPIN: begin
                    if (stop || model_done(m)) n.st = DRAIN;
                    else if (pause) n.st = PAUSED;
                end
                DRAIN: begin
                    if (!water_full) begin
                        n.cnt = (m.cnt == 2'd3) ? m.cnt : m.cnt + 2'd1;
                        if (stop) n.st = IDLE;
                        else if (n.cnt == 2'd1) n.st = RINSE;
                        else if (n.cnt == 2'd2) n.st = SPIN;
                        else n.st = COMPLETE;
                    end
                end
                COMPLETE: begin
                    n.lock = 1'b0;
                    n.cnt  = '0;
                    n.st   = IDLE;
                end
                PAUSED: begin
                    if (stop) n.st = DRAIN;
                    else if (model_resume(m)) n.st = m.saved;
                end
                default: n.st = INIT;
            endcase
        end
        // Timer loads on entry and freezes outside timed phases
        if (m.entry) n.tcnt = phase_len(m.st);
        else if (is_timed(m.st) && m.tcnt != '0) n.tcnt = m.tcnt - timer_count_t'(1);
        if (m.st == OFF) begin
            n.fault = FAULT_NONE;
        end else if (n.st == PAUSED && m.st != PAUSED) begin
            n.fault = why;
            n.saved = m.st;
        end else if (model_resume(m)) begin
            n.fault = FAULT_NONE;
        end
        n.entry = is_timed(n.st) && n.st != m.st && m.st != PAUSED;
        return n;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) model <= '0;  // All zero is INIT with no fault
        else model <= model_step(model);
    end

    // Outputs are settled half a cycle after the edge
    always @(negedge clk) begin
        check_state("state", state, model.st);
        check_bit("door_locked", door_locked, model.lock);
        check_count("drain_count", drain_count, model.cnt);
        check_bit("timer_done", timer_done, model_done(model));
        check_fault("fault_code", fault_code, model.fault);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic wait_for(input wm_state_t s);
        while (state != s) begin
            tick(1);
        end
    endtask

    task automatic press_start();
        start = 1'b1;
        tick(1);
        start = 1'b0;
    endtask

    task automatic power_cycle();
        pwr_btn = 1'b0;
        tick(2);
        pwr_btn = 1'b1;
        wait_for(IDLE);
    endtask

    task automatic run_program(input wash_mode_t md);
        timer_count_t n;
        mode = md;
        press_start();
        tick(2);
        water_full = 1'b1;
        wait_for(WASH);
        check_bit("door_locked", door_locked, 1'b1);
        n = '0;
        while (state == WASH) begin
            n = n + timer_count_t'(1);
            tick(1);
        end
        check_time("wash cycles", n, exp_wash_time(md) + timer_count_t'(2));
        water_full = 1'b0;
        wait_for(RINSE);
        wait_for(SPIN);
        wait_for(COMPLETE);
        wait_for(IDLE);
        check_bit("door_locked", door_locked, 1'b0);
        check_count("drain_count", drain_count, 2'd0);
    endtask

    initial begin
        timer_count_t n;
        void'($urandom(32'hc28d));
        rst          = 1'b1;
        pwr_btn      = 1'b1;
        start        = 1'b0;
        stop         = 1'b0;
        pause        = 1'b0;
        door_closed  = 1'b1;
        water_full   = 1'b0;
        load_present = 1'b1;
        mode         = '0;
        tick(2);
        rst = 1'b0;

        begin_test();
        wait_for(IDLE);
        press_start();
        water_full = 1'b1;
        wait_for(WASH);
        check_bit("door_locked", door_locked, 1'b1);
        pwr_btn    = 1'b0;
        water_full = 1'b0;
        tick(1);
        check_state("state", state, OFF);
        tick(1);
        check_bit("door_locked", door_locked, 1'b0);
        pwr_btn = 1'b1;
        wait_for(IDLE);
        press_start();
        door_closed = 1'b0;
        wait_for(PAUSED);
        check_fault("fault_code", fault_code, FAULT_DOOR);
        pwr_btn = 1'b0;
        tick(2);
        check_fault("fault_code", fault_code, FAULT_NONE);
        door_closed = 1'b1;
        pwr_btn     = 1'b1;
        wait_for(IDLE);
        end_test("power-up and power loss");

        begin_test();
        repeat (3) begin
            run_program(wash_mode_t'($urandom % 8));
        end
        end_test("full program");

        begin_test();
        press_start();
        door_closed = 1'b0;
        tick(1);
        check_fault("fault_code", fault_code, FAULT_DOOR);
        door_closed = 1'b1;
        tick(1);
        check_state("state", state, FILL);
        load_present = 1'b0;
        tick(1);
        check_fault("fault_code", fault_code, FAULT_LOAD);
        load_present = 1'b1;
        tick(1);
        check_state("state", state, FILL);
        wait_for(PAUSED);             // Fill time runs out
        check_fault("fault_code", fault_code, FAULT_WATER);
        water_full = 1'b1;
        tick(2);
        check_state("state", state, WASH);
        water_full = 1'b0;
        power_cycle();
        end_test("fill faults");

        begin_test();
        mode = wash_mode_t'($urandom % 8);
        press_start();
        water_full = 1'b1;
        wait_for(WASH);
        tick(2);
        pause = 1'b1;                 // Third WASH cycle
        tick(1);
        pause = 1'b0;
        tick(4);
        check_state("state", state, PAUSED);
        press_start();
        n = timer_count_t'(3);
        while (state == WASH) begin
            n = n + timer_count_t'(1);
            tick(1);
        end
        check_time("wash cycles", n, exp_wash_time(mode) + timer_count_t'(2));
        check_state("state", state, DRAIN);
        water_full = 1'b0;
        power_cycle();
        end_test("user pause");

        begin_test();
        press_start();
        water_full = 1'b1;
        wait_for(WASH);
        stop = 1'b1;
        tick(1);
        stop = 1'b0;
        check_state("state", state, DRAIN);
        water_full = 1'b0;
        wait_for(RINSE);
        stop = 1'b1;
        tick(1);
        stop = 1'b0;
        check_state("state", state, DRAIN);
        wait_for(SPIN);
        pause = 1'b1;
        tick(1);
        pause = 1'b0;
        stop  = 1'b1;
        tick(1);
        check_state("state", state, DRAIN);
        tick(1);
        stop = 1'b0;
        check_state("state", state, IDLE);
        end_test("stop");

        // Stopped program leaves three drains counted and the door locked
        begin_test();
        check_count("drain_count", drain_count, 2'd3);
        check_bit("door_locked", door_locked, 1'b1);
        pwr_btn = 1'b0;
        tick(1);
        check_state("state", state, OFF);
        tick(1);
        check_bit("door_locked", door_locked, 1'b0);
        check_count("drain_count", drain_count, 2'd0);
        pwr_btn = 1'b1;
        wait_for(IDLE);
        end_test("power loss with drains counted");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- washer_top.sv
`timescale 1ns/100ps

module washer_top
    import wm_pkg::*;
#(
    parameter int FILL_TIME       = 5,
    parameter int RINSE_SPIN_TIME = 5
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         pwr_btn,
    input  logic         start,
    input  logic         stop,
    input  logic         pause,
    input  logic         door_closed,
    input  wash_mode_t   mode,
    input  logic         water_full,
    input  logic         load_present,
    output wm_state_t    state,
    output logic         door_locked,
    output drain_count_t drain_count,
    output logic         timer_done,
    output fault_t       fault_code
);

    logic      phase_entry;
    logic      pause_save;
    fault_t    pause_fault;
    logic      resume_ok;
    wm_state_t resume_state;

    cycle_fsm fsm_i (
        .clk          (clk),
        .rst          (rst),
        .pwr_btn      (pwr_btn),
        .start        (start),
        .stop         (stop),
        .pause        (pause),
        .door_closed  (door_closed),
        .water_full   (water_full),
        .load_present (load_present),
        .timer_done   (timer_done),
        .resume_ok    (resume_ok),
        .resume_state (resume_state),
        .state        (state),
        .door_locked  (door_locked),
        .drain_count  (drain_count),
        .phase_entry  (phase_entry),
        .pause_save   (pause_save),
        .pause_fault  (pause_fault)
    );

    phase_timer #(
        .FILL_TIME       (FILL_TIME),
        .RINSE_SPIN_TIME (RINSE_SPIN_TIME)
    ) timer_i (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .mode        (mode),
        .phase_entry (phase_entry),
        .timer_done  (timer_done)
    );

    pause_keeper keeper_i (
        .clk          (clk),
        .rst          (rst),
        .state        (state),
        .pause_save   (pause_save),
        .pause_fault  (pause_fault),
        .door_closed  (door_closed),
        .water_full   (water_full),
        .load_present (load_present),
        .start        (start),
        .resume_ok    (resume_ok),
        .resume_state (resume_state),
        .fault_code   (fault_code)
    );

endmodule

//--- cycle_fsm.sv
`timescale 1ns/100ps

module cycle_fsm
    import wm_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         pwr_btn,
    input  logic         start,
    input  logic         stop,
    input  logic         pause,
    input  logic         door_closed,
    input  logic         water_full,
    input  logic         load_present,
    input  logic         timer_done,
    input  logic         resume_ok,
    input  wm_state_t    resume_state,
    output wm_state_t    state,
    output logic         door_locked,
    output drain_count_t drain_count,
    output logic         phase_entry,
    output logic         pause_save,
    output fault_t       pause_fault
);

    wm_state_t    next_state;
    logic         next_lock;
    drain_count_t next_count;
    logic         next_entry;

    always_comb begin
        next_state  = state;
        next_lock   = door_locked;
        next_count  = drain_count;
        pause_fault = FAULT_NONE;

        if (state == OFF) begin
            next_lock  = 1'b0;
            next_count = '0;
        end

        if (!pwr_btn) begin
            next_state = OFF;                     // Power loss overrides everything
        end else begin
            case (state)
                OFF:  next_state = INIT;
                INIT: next_state = IDLE;

                IDLE: begin
                    if (start) next_state = FILL;
                end

                FILL: begin
                    if (stop) begin
                        next_state = DRAIN;
                    end else if (!door_closed) begin
                        next_state  = PAUSED;
                        pause_fault = FAULT_DOOR;
                    end else if (!load_present) begin
                        next_state  = PAUSED;
                        pause_fault = FAULT_LOAD;
                    end else if (water_full) begin
                        next_state = WASH;
                        next_lock  = 1'b1;        // Lock before the drum turns
                    end else if (timer_done) begin
                        next_state  = PAUSED;     // Level not reached in time
                        pause_fault = FAULT_WATER;
                    end
                end

                WASH: begin
                    if (timer_done) begin
                        next_state = DRAIN;
                    end else if (pause) begin
                        next_state = PAUSED;
                    end else if (stop) begin
                        next_state = DRAIN;
                    end
                end

                RINSE, SPIN: begin
                    if (stop || timer_done) begin
                        next_state = DRAIN;
                    end else if (pause) begin
                        next_state = PAUSED;
                    end
                end

                DRAIN: begin
                    // Tub empty, so this drain is done
                    if (!water_full) begin
                        if (drain_count != 2'd3) begin
                            next_count = drain_count + 2'd1;
                        end
                        if (stop) begin
                            next_state = IDLE;
                        end else begin
                            case (next_count)
                                2'd1:    next_state = RINSE;
                                2'd2:    next_state = SPIN;
                                default: next_state = COMPLETE;
                            endcase
                        end
                    end
                end

                COMPLETE: begin
                    next_lock  = 1'b0;
                    next_count = '0;
                    next_state = IDLE;
                end

                PAUSED: begin
                    if (stop) begin
                        next_state = DRAIN;
                    end else if (resume_ok) begin
                        next_state = resume_state;
                    end
                end

                default: next_state = INIT;
            endcase
        end
    end

    // Pause keeper snapshots on this edge
    assign pause_save = (next_state == PAUSED) && (state != PAUSED);

    // Fresh entry only; a resume keeps the timer's remaining count
    assign next_entry = (next_state inside {FILL, WASH, RINSE, SPIN})
                        && (next_state != state) && (state != PAUSED);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= INIT;
            door_locked <= 1'b0;
            drain_count <= '0;
            phase_entry <= 1'b0;
        end else begin
            state       <= next_state;
            door_locked <= next_lock;
            drain_count <= next_count;
            phase_entry <= next_entry;
        end
    end

endmodule

//--- pause_keeper.sv
`timescale 1ns/100ps

module pause_keeper
    import wm_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  wm_state_t state,
    input  logic      pause_save,
    input  fault_t    pause_fault,
    input  logic      door_closed,
    input  logic      water_full,
    input  logic      load_present,
    input  logic      start,
    output logic      resume_ok,
    output wm_state_t resume_state,
    output fault_t    fault_code
);

    wm_state_t saved_state;
    fault_t    fault_q;

    // State to go back to once the pause ends
    always_ff @(posedge clk) begin
        if (pause_save) begin
            saved_state <= state;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fault_q <= FAULT_NONE;
        end else if (state == OFF) begin
            fault_q <= FAULT_NONE;
        end else if (pause_save) begin
            fault_q <= pause_fault;
        end else if (resume_ok) begin
            fault_q <= FAULT_NONE;                // Cleared as the machine resumes
        end
    end

    // Each fault waits for its own sensor; a user pause waits for start
    always_comb begin
        resume_ok = 1'b0;
        if (state == PAUSED) begin
            case (fault_q)
                FAULT_DOOR:  resume_ok = door_closed;
                FAULT_WATER: resume_ok = water_full;
                FAULT_LOAD:  resume_ok = load_present;
                default:     resume_ok = start;
            endcase
        end
    end

    assign resume_state = saved_state;
    assign fault_code   = fault_q;

endmodule

//--- phase_timer.sv
`timescale 1ns/100ps

module phase_timer
    import wm_pkg::*;
#(
    parameter int FILL_TIME       = 5,
    parameter int RINSE_SPIN_TIME = 5
) (
    input  logic       clk,
    input  logic       rst,
    input  wm_state_t  state,
    input  wash_mode_t mode,
    input  logic       phase_entry,
    output logic       timer_done
);

    timer_count_t count;
    timer_count_t duration;
    logic         timed;

    // Only these phases run against the clock
    assign timed = state inside {FILL, WASH, RINSE, SPIN};

    // Length of the phase being entered
    always_comb begin
        case (state)
            FILL:        duration = timer_count_t'(FILL_TIME);
            WASH:        duration = wash_time(mode);
            RINSE, SPIN: duration = timer_count_t'(RINSE_SPIN_TIME);
            default:     duration = '0;
        endcase
    end

    // Load on entry, then count down
    // Outside timed states the count just holds, so a pause keeps the rest
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (phase_entry) begin
            count <= duration;
        end else if (timed && count != '0) begin
            count <= count - timer_count_t'(1);
        end
    end

    // The entry cycle still sees the old count, so it is masked
    assign timer_done = timed && (count == '0) && !phase_entry;

endmodule

//--- wm_pkg.sv
package wm_pkg;

    // Machine states, INIT at zero
    typedef enum logic [3:0] {
        INIT     = 4'd0,
        IDLE     = 4'd1,
        FILL     = 4'd2,
        WASH     = 4'd3,
        DRAIN    = 4'd4,
        RINSE    = 4'd5,
        SPIN     = 4'd6,
        COMPLETE = 4'd7,
        OFF      = 4'd8,
        PAUSED   = 4'd9
    } wm_state_t;

    // Sensor fault that put the machine in PAUSED
    typedef enum logic [1:0] {
        FAULT_NONE  = 2'd0,
        FAULT_DOOR  = 2'd1,
        FAULT_WATER = 2'd2,
        FAULT_LOAD  = 2'd3
    } fault_t;

    typedef logic [2:0] wash_mode_t;    // Program selector
    typedef logic [1:0] drain_count_t;  // Drains done in this program

    localparam int TIMER_W = 8;
    typedef logic [TIMER_W-1:0] timer_count_t;

    // Wash duration per program, in clock cycles
    function automatic timer_count_t wash_time(input wash_mode_t mode);
        case (mode)
            3'd0:    return timer_count_t'(20);  // Whites
            3'd1:    return timer_count_t'(30);  // Heavy duty
            3'd2:    return timer_count_t'(15);  // Normal
            3'd3:    return timer_count_t'(10);  // Eco
            3'd4:    return timer_count_t'(5);   // Quick
            3'd5:    return timer_count_t'(25);  // Bulky
            default: return timer_count_t'(15);  // Unused codes run as normal
        endcase
    endfunction

endpackage
